/* gfx_demo.sv */
`timescale 1ns/1ns

module gfx_demo #(
  parameter int H_VISIBLE  = 640,
  parameter int H_FRONT    = 16,
  parameter int H_SYNC     = 96,
  parameter int H_BACK     = 48,
  parameter int V_VISIBLE  = 480,
  parameter int V_FRONT    = 10,
  parameter int V_SYNC     = 2,
  parameter int V_BACK     = 33,
  parameter int NUM_LANES  = 4,
  parameter int LANE_DEPTH = 2
) (
  input  logic                           clk,
  input  logic                           reset,
  input  gfx_pkg::pattern_e              pattern,
  input  gfx_pkg::pixel_t                solid_color,
  output logic [gfx_pkg::color_bits-1:0] vga_red,
  output logic [gfx_pkg::color_bits-1:0] vga_grn,
  output logic [gfx_pkg::color_bits-1:0] vga_blu,
  output logic                           vga_hsync,
  output logic                           vga_vsync,
  output logic                           underflow
);
  localparam int OUT_DEPTH = 4;

  gfx_pkg::lane_req_t [NUM_LANES-1:0] req;
  logic [NUM_LANES-1:0]               req_valid;
  gfx_pkg::lane_res_t [NUM_LANES-1:0] res;
  logic [NUM_LANES-1:0]               not_empty;
  logic [NUM_LANES-1:0]               pop;
  gfx_pkg::pixel_t                    pix;
  logic                               pix_avail;
  logic                               take;

  // Pops double as credit returns.
  pixel_dispatch #(
    .H_VISIBLE (H_VISIBLE),
    .V_VISIBLE (V_VISIBLE),
    .NUM_LANES (NUM_LANES),
    .LANE_DEPTH(LANE_DEPTH)
  ) u_dispatch (
    .clk        (clk),
    .reset      (reset),
    .pattern    (pattern),
    .solid_color(solid_color),
    .credit_ret (pop),
    .req        (req),
    .req_valid  (req_valid)
  );

  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    pattern_lane #(
      .LANE_DEPTH(LANE_DEPTH)
    ) u_lane (
      .clk      (clk),
      .reset    (reset),
      .req      (req[g]),
      .req_valid(req_valid[g]),
      .pop      (pop[g]),
      .res      (res[g]),
      .not_empty(not_empty[g])
    );
  end

  pixel_collect #(
    .NUM_LANES(NUM_LANES),
    .OUT_DEPTH(OUT_DEPTH)
  ) u_collect (
    .clk      (clk),
    .reset    (reset),
    .res      (res),
    .not_empty(not_empty),
    .take     (take),
    .pop      (pop),
    .pix      (pix),
    .pix_avail(pix_avail)
  );

  vga_timing #(
    .H_VISIBLE(H_VISIBLE),
    .H_FRONT  (H_FRONT),
    .H_SYNC   (H_SYNC),
    .H_BACK   (H_BACK),
    .V_VISIBLE(V_VISIBLE),
    .V_FRONT  (V_FRONT),
    .V_SYNC   (V_SYNC),
    .V_BACK   (V_BACK)
  ) u_timing (
    .clk      (clk),
    .reset    (reset),
    .pix      (pix),
    .pix_avail(pix_avail),
    .take     (take),
    .vga_red  (vga_red),
    .vga_grn  (vga_grn),
    .vga_blu  (vga_blu),
    .vga_hsync(vga_hsync),
    .vga_vsync(vga_vsync),
    .underflow(underflow)
  );

endmodule

/* gfx_demo_sva.sv */
`timescale 1ns/1ns

module gfx_demo_sva #(
  parameter int NUM_LANES  = 4,
  parameter int LANE_DEPTH = 2
) (
  input logic                 clk,
  input logic                 reset,
  input logic [NUM_LANES-1:0] req_valid,
  input logic [NUM_LANES-1:0] pop,
  input logic [NUM_LANES-1:0] not_empty,
  input logic                 vga_hsync,
  input logic                 vga_vsync
);

  // Both syncs inactive as reset lets go.
  a_sync_idle: assert property (@(posedge clk) $fell(reset) |=> (vga_hsync && vga_vsync))
    else $error("sync output low in the cycle after reset");

  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    int   in_flight;
    int   stored;
    logic arrived;

    // Requests sent minus results popped.
    always_ff @(posedge clk) begin
      if (reset) begin
        in_flight <= 0;
      end else begin
        in_flight <= in_flight + int'(req_valid[g]) - int'(pop[g]);
      end
    end

    // A request lands in the lane FIFO two cycles after it is sent.
    always_ff @(posedge clk) begin
      if (reset) begin
        arrived <= 1'b0;
        stored  <= 0;
      end else begin
        arrived <= req_valid[g];
        stored  <= stored + int'(arrived) - int'(pop[g]);
      end
    end

    a_credit_bound: assert property (@(posedge clk) disable iff (reset)
      in_flight <= LANE_DEPTH)
      else $error("lane %0d received a request without credit", g);

    a_pop_not_empty: assert property (@(posedge clk) disable iff (reset)
      pop[g] |-> stored > 0)
      else $error("lane %0d popped while empty", g);

    a_not_empty_track: assert property (@(posedge clk) disable iff (reset)
      not_empty[g] == (stored != 0))
      else $error("lane %0d not-empty flag disagrees with its contents", g);
  end

endmodule

bind gfx_demo gfx_demo_sva #(
  .NUM_LANES (NUM_LANES),
  .LANE_DEPTH(LANE_DEPTH)
) u_sva (
  .clk      (clk),
  .reset    (reset),
  .req_valid(req_valid),
  .pop      (pop),
  .not_empty(not_empty),
  .vga_hsync(vga_hsync),
  .vga_vsync(vga_vsync)
);

/* gfx_pkg.sv */
package gfx_pkg;

  localparam int color_bits = 4;
  localparam int coord_bits = 10;
  localparam int frame_bits = 4;

  // Pattern selection opcodes.
  typedef enum logic [1:0] {
    pat_solid,
    pat_xor,
    pat_gradient,
    pat_checker
  } pattern_e;

  typedef struct packed {
    logic [color_bits-1:0] red;
    logic [color_bits-1:0] grn;
    logic [color_bits-1:0] blu;
  } pixel_t;

  // One pixel job for a lane.
  typedef struct packed {
    logic [coord_bits-1:0] x;
    logic [coord_bits-1:0] y;
    logic [frame_bits-1:0] frame;
    pattern_e              pattern;
    pixel_t                solid;
  } lane_req_t;

  typedef struct packed {
    pixel_t pix;
  } lane_res_t;

endpackage

/* pattern_lane.sv */
`timescale 1ns/1ns

module pattern_lane #(
  parameter int LANE_DEPTH = 2
) (
  input  logic               clk,
  input  logic               reset,
  input  gfx_pkg::lane_req_t req,
  input  logic               req_valid,
  input  logic               pop,
  output gfx_pkg::lane_res_t res,
  output logic               not_empty
);
  localparam int CB = gfx_pkg::color_bits;
  localparam int AW = (LANE_DEPTH > 1) ? $clog2(LANE_DEPTH) : 1;
  localparam int CW = $clog2(LANE_DEPTH + 1);

  logic                           s1_valid;
  gfx_pkg::pattern_e              s1_op;
  gfx_pkg::pixel_t                s1_solid;
  logic [CB-1:0]                  s1_xor;
  logic [CB-1:0]                  s1_xlo;
  logic [CB-1:0]                  s1_ylo;
  logic [CB-1:0]                  s1_xmid;
  logic [CB-1:0]                  s1_ymid;
  logic [gfx_pkg::frame_bits-1:0] s1_frame;
  logic                           s1_check;
  gfx_pkg::pixel_t                pix_new;

  gfx_pkg::lane_res_t mem [LANE_DEPTH];
  logic [AW-1:0]      wr_ptr;
  logic [AW-1:0]      rd_ptr;
  logic [CW-1:0]      count;

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= req_valid;
    end
  end

  // Stage one computes the pattern terms.
  always_ff @(posedge clk) begin
    s1_op    <= req.pattern;
    s1_solid <= req.solid;
    s1_xor   <= req.x[CB-1:0] ^ req.y[CB-1:0];
    s1_xlo   <= req.x[CB-1:0];
    s1_ylo   <= req.y[CB-1:0];
    s1_xmid  <= req.x[CB:1];
    s1_ymid  <= req.y[CB:1];
    s1_frame <= req.frame;
    s1_check <= req.x[2] ^ req.y[2] ^ req.frame[0];
  end

  // Stage two selects the colour.
  always_comb begin
    case (s1_op)
      gfx_pkg::pat_solid:    pix_new = s1_solid;
      gfx_pkg::pat_xor:      pix_new = '{red: s1_xor, grn: s1_xlo, blu: s1_ylo};
      gfx_pkg::pat_gradient: pix_new = '{red: s1_xmid, grn: s1_ymid, blu: s1_frame};
      default:               pix_new = s1_check ? '1 : '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (s1_valid) begin
        wr_ptr <= (wr_ptr == AW'(LANE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == AW'(LANE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CW'(s1_valid) - CW'(pop);
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      mem[wr_ptr].pix <= pix_new;
    end
  end

  assign res       = mem[rd_ptr];
  assign not_empty = count != '0;

endmodule

/* pixel_collect.sv */
`timescale 1ns/1ns

module pixel_collect #(
  parameter int NUM_LANES = 4,
  parameter int OUT_DEPTH = 4
) (
  input  logic                                clk,
  input  logic                                reset,
  input  gfx_pkg::lane_res_t [NUM_LANES-1:0]  res,
  input  logic [NUM_LANES-1:0]                not_empty,
  input  logic                                take,
  output logic [NUM_LANES-1:0]                pop,
  output gfx_pkg::pixel_t                     pix,
  output logic                                pix_avail
);
  localparam int TW = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
  localparam int AW = (OUT_DEPTH > 1) ? $clog2(OUT_DEPTH) : 1;
  localparam int CW = $clog2(OUT_DEPTH + 1);

  logic [TW-1:0]   turn;
  gfx_pkg::pixel_t mem [OUT_DEPTH];
  logic [AW-1:0]   wr_ptr;
  logic [AW-1:0]   rd_ptr;
  logic [CW-1:0]   count;
  logic            out_pop;
  logic            room;
  logic            grab;

  assign out_pop = take && (count != '0);
  // A slot freed by this cycle's read counts as room.
  assign room    = (count != CW'(OUT_DEPTH)) || out_pop;
  assign grab    = not_empty[turn] && room;

  always_comb begin
    pop       = '0;
    pop[turn] = grab;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      turn   <= '0;
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (grab) begin
        turn   <= (turn == TW'(NUM_LANES - 1)) ? '0 : turn + 1'b1;
        wr_ptr <= (wr_ptr == AW'(OUT_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (out_pop) begin
        rd_ptr <= (rd_ptr == AW'(OUT_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CW'(grab) - CW'(out_pop);
    end
  end

  always_ff @(posedge clk) begin
    if (grab) begin
      mem[wr_ptr] <= res[turn].pix;
    end
  end

  assign pix       = mem[rd_ptr];
  assign pix_avail = count != '0;

endmodule

/* pixel_dispatch.sv */
`timescale 1ns/1ns

module pixel_dispatch #(
  parameter int H_VISIBLE  = 640,
  parameter int V_VISIBLE  = 480,
  parameter int NUM_LANES  = 4,
  parameter int LANE_DEPTH = 2
) (
  input  logic                                clk,
  input  logic                                reset,
  input  gfx_pkg::pattern_e                   pattern,
  input  gfx_pkg::pixel_t                     solid_color,
  input  logic [NUM_LANES-1:0]                credit_ret,
  output gfx_pkg::lane_req_t [NUM_LANES-1:0]  req,
  output logic [NUM_LANES-1:0]                req_valid
);
  localparam int TW     = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
  localparam int CW     = $clog2(LANE_DEPTH + 1);
  localparam int X_LAST = H_VISIBLE - 1;
  localparam int Y_LAST = V_VISIBLE - 1;

  logic [gfx_pkg::coord_bits-1:0] cur_x;
  logic [gfx_pkg::coord_bits-1:0] cur_y;
  logic [gfx_pkg::frame_bits-1:0] frame_q;
  gfx_pkg::pattern_e              pat_q;
  gfx_pkg::pixel_t                solid_q;
  logic [TW-1:0]                  turn;
  logic [CW-1:0]                  credit [NUM_LANES];
  logic                           issue;
  logic                           at_origin;
  gfx_pkg::lane_req_t             tag;

  assign issue     = credit[turn] != '0;
  assign at_origin = (cur_x == '0) && (cur_y == '0);

  // New frame settings take effect on the origin pixel itself.
  always_comb begin
    tag.x       = cur_x;
    tag.y       = cur_y;
    tag.frame   = at_origin ? frame_q + 1'b1 : frame_q;
    tag.pattern = at_origin ? pattern : pat_q;
    tag.solid   = at_origin ? solid_color : solid_q;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      cur_x     <= '0;
      cur_y     <= '0;
      frame_q   <= '1;
      turn      <= '0;
      req_valid <= '0;
    end else begin
      req_valid <= '0;
      if (issue) begin
        req_valid[turn] <= 1'b1;
        turn <= (turn == TW'(NUM_LANES - 1)) ? '0 : turn + 1'b1;
        if (at_origin) begin
          frame_q <= tag.frame;
        end
        if (cur_x == X_LAST[gfx_pkg::coord_bits-1:0]) begin
          cur_x <= '0;
          cur_y <= (cur_y == Y_LAST[gfx_pkg::coord_bits-1:0]) ? '0 : cur_y + 1'b1;
        end else begin
          cur_x <= cur_x + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      req[turn] <= tag;
      if (at_origin) begin
        pat_q   <= pattern;
        solid_q <= solid_color;
      end
    end
  end

  // One credit counter per lane.
  for (genvar g = 0; g < NUM_LANES; g++) begin : g_credit
    logic spend;

    assign spend = issue && (turn == TW'(g));

    always_ff @(posedge clk) begin
      if (reset) begin
        credit[g] <= CW'(LANE_DEPTH);
      end else begin
        credit[g] <= credit[g] - CW'(spend) + CW'(credit_ret[g]);
      end
    end
  end

endmodule

/* project.f */
gfx_pkg.sv
vga_timing.sv
pixel_dispatch.sv
pattern_lane.sv
pixel_collect.sv
gfx_demo.sv
gfx_demo_sva.sv
tb_gfx_demo.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_gfx_demo -f project.f \
  > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/Vtb_gfx_demo > sim.log 2>&1 && cat sim.log \
  || { cat sim.log; echo "Simulation exited with an error"; exit 1; }

grep -q "Checks failed" sim.log && { echo "Result: FAIL"; exit 1; } \
  || { echo "Result: PASS"; exit 0; }

/* tb_gfx_demo.sv */
`timescale 1ns/1ns

module tb_gfx_demo;

  localparam int H_VISIBLE  = 16;
  localparam int H_FRONT    = 4;
  localparam int H_SYNC     = 2;
  localparam int H_BACK     = 2;
  localparam int V_VISIBLE  = 6;
  localparam int V_FRONT    = 1;
  localparam int V_SYNC     = 1;
  localparam int V_BACK     = 1;
  localparam int NUM_LANES  = 4;
  localparam int LANE_DEPTH = 2;

  localparam int H_TOTAL         = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL         = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;
  localparam int HS_START        = H_VISIBLE + H_FRONT;
  localparam int VS_START        = V_VISIBLE + V_FRONT;
  localparam int NUM_FRAMES      = 10;
  localparam int CLK_PERIOD      = 40;
  localparam int WATCHDOG_CYCLES = 12 * H_TOTAL * V_TOTAL + 200;

  typedef struct packed {
    gfx_pkg::pixel_t pix;
    logic            hs;
    logic            vs;
  } vga_sample_t;

  logic                           clk;
  logic                           reset;
  gfx_pkg::pattern_e              pattern;
  gfx_pkg::pixel_t                solid_color;
  logic [gfx_pkg::color_bits-1:0] vga_red;
  logic [gfx_pkg::color_bits-1:0] vga_grn;
  logic [gfx_pkg::color_bits-1:0] vga_blu;
  logic                           vga_hsync;
  logic                           vga_vsync;
  logic                           underflow;

  // Per-frame pattern and colour. Index 0 is live from reset.
  gfx_pkg::pattern_e frame_pat [NUM_FRAMES+1];
  gfx_pkg::pixel_t   frame_col [NUM_FRAMES+1];
  int                change_req;
  int                change_done;

  vga_sample_t pending [$];
  int          h_pos;
  int          v_pos;
  int          frame_idx;
  int          err_idle;
  int          err_sync;
  int          err_pix;
  int          err_blank;
  int          err_anim;
  int          err_uflow;
  int          anim_checked;
  int          tests_run;
  int          tests_failed;
  int          total_errors;

  gfx_demo #(
    .H_VISIBLE (H_VISIBLE),
    .H_FRONT   (H_FRONT),
    .H_SYNC    (H_SYNC),
    .H_BACK    (H_BACK),
    .V_VISIBLE (V_VISIBLE),
    .V_FRONT   (V_FRONT),
    .V_SYNC    (V_SYNC),
    .V_BACK    (V_BACK),
    .NUM_LANES (NUM_LANES),
    .LANE_DEPTH(LANE_DEPTH)
  ) u_dut (
    .clk        (clk),
    .reset      (reset),
    .pattern    (pattern),
    .solid_color(solid_color),
    .vga_red    (vga_red),
    .vga_grn    (vga_grn),
    .vga_blu    (vga_blu),
    .vga_hsync  (vga_hsync),
    .vga_vsync  (vga_vsync),
    .underflow  (underflow)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic gfx_pkg::pixel_t model_pixel(input int x, input int y, input int frame,
                                                  input gfx_pkg::pattern_e pat,
                                                  input gfx_pkg::pixel_t solid);
    logic [9:0]      xb;
    logic [9:0]      yb;
    logic [3:0]      fb;
    gfx_pkg::pixel_t p;
    xb = x[9:0];
    yb = y[9:0];
    fb = frame[3:0];
    case (pat)
      gfx_pkg::pat_solid: p = solid;
      gfx_pkg::pat_xor: begin
        p.red = xb[3:0] ^ yb[3:0];
        p.grn = xb[3:0];
        p.blu = yb[3:0];
      end
      gfx_pkg::pat_gradient: begin
        p.red = xb[4:1];
        p.grn = yb[4:1];
        p.blu = fb;
      end
      default: p = (xb[2] != (yb[2] ^ fb[0])) ? 12'hfff : 12'h000;
    endcase
    return p;
  endfunction

  task automatic report_test(input string name, input int errors);
    tests_run++;
    total_errors += errors;
    if (errors == 0) begin
      $display("Test %-15s passed", name);
    end else begin
      tests_failed++;
      $display("Test %-15s FAILED with %0d errors", name, errors);
    end
  endtask

  // Compares one output sample with the model, then steps the scan position.
  task automatic check_sample(input vga_sample_t s);
    logic              exp_hs;
    logic              exp_vs;
    logic              animated;
    gfx_pkg::pixel_t   exp_pix;
    gfx_pkg::pattern_e pat;
    pat    = frame_pat[frame_idx];
    exp_hs = !(h_pos >= HS_START && h_pos < HS_START + H_SYNC);
    exp_vs = !(v_pos >= VS_START && v_pos < VS_START + V_SYNC);
    if (s.hs != exp_hs || s.vs != exp_vs) begin
      err_sync++;
      $display("CHECK FAILED @%0t: syncs at (%0d,%0d) are %b%b, expected %b%b",
               $time, h_pos, v_pos, s.hs, s.vs, exp_hs, exp_vs);
    end
    if (h_pos < H_VISIBLE && v_pos < V_VISIBLE) begin
      exp_pix  = model_pixel(h_pos, v_pos, frame_idx, pat, frame_col[frame_idx]);
      animated = (pat == gfx_pkg::pat_gradient || pat == gfx_pkg::pat_checker) &&
                 frame_idx > 0;
      if (animated) begin
        anim_checked++;
      end
      if (s.pix != exp_pix) begin
        err_pix++;
        if (animated) begin
          err_anim++;
        end
        $display("CHECK FAILED @%0t: frame %0d %s pixel (%0d,%0d) got %h expected %h",
                 $time, frame_idx, pat.name(), h_pos, v_pos, s.pix, exp_pix);
      end
    end else if (s.pix != '0) begin
      err_blank++;
      $display("CHECK FAILED @%0t: blanking (%0d,%0d) got colour %h",
               $time, h_pos, v_pos, s.pix);
    end
    if (h_pos == 0 && v_pos == V_VISIBLE / 2) begin
      change_req++;
    end
    if (h_pos == H_TOTAL - 1) begin
      h_pos = 0;
      if (v_pos == V_TOTAL - 1) begin
        v_pos = 0;
        frame_idx++;
      end else begin
        v_pos++;
      end
    end else begin
      h_pos++;
    end
  endtask

  // First hsync pulse pins down where line 0 began in the recorded samples.
  task automatic replay_first_line(input vga_sample_t s);
    int first;
    first = pending.size() - HS_START;
    if (first < 0) begin
      err_idle++;
      $display("CHECK FAILED @%0t: hsync pulse came before a full line of output", $time);
      first = 0;
    end
    for (int i = 0; i < first; i++) begin
      if (pending[i].pix != '0 || !pending[i].hs || !pending[i].vs) begin
        err_idle++;
        $display("CHECK FAILED @%0t: output not idle before scan start, sample %0d",
                 $time, i);
      end
    end
    report_test("reset_idle", err_idle);
    for (int i = first; i < pending.size(); i++) begin
      check_sample(pending[i]);
    end
    check_sample(s);
    pending.delete();
  endtask

  task automatic finish_run();
    report_test("sync_timing", err_sync);
    report_test("visible_pixels", err_pix);
    report_test("blanking_zero", err_blank);
    if (anim_checked == 0) begin
      err_anim++;
      $display("No gradient or checker frame after frame 0 was shown, animation untested");
    end
    report_test("animation", err_anim);
    report_test("underflow", err_uflow);
    $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
             tests_run, tests_run - tests_failed, tests_failed, total_errors);
    if (tests_failed == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  endtask

  initial begin : stimulus
    int order [4];
    int j;
    int tmp;
    void'($urandom(37080));
    // Opcodes shuffled in blocks of four so every pattern shows up.
    for (int b = 0; b <= NUM_FRAMES; b += 4) begin
      order = '{0, 1, 2, 3};
      for (int i = 3; i > 0; i--) begin
        j        = $urandom_range(i);
        tmp      = order[i];
        order[i] = order[j];
        order[j] = tmp;
      end
      for (int i = 0; i < 4; i++) begin
        if (b + i <= NUM_FRAMES) begin
          frame_pat[b+i] = gfx_pkg::pattern_e'(order[i][1:0]);
        end
      end
    end
    for (int f = 0; f <= NUM_FRAMES; f++) begin
      tmp          = $urandom;
      frame_col[f] = tmp[11:0];
    end
    change_done = 0;
    pattern     = frame_pat[0];
    solid_color = frame_col[0];
    reset       = 1'b1;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    forever begin
      @(posedge clk);
      if (change_done != change_req) begin
        change_done = change_done + 1;
        pattern     <= frame_pat[change_done];
        solid_color <= frame_col[change_done];
      end
    end
  end

  initial begin : monitor
    vga_sample_t s;
    bit          aligned;
    change_req   = 0;
    h_pos        = 0;
    v_pos        = 0;
    frame_idx    = 0;
    err_idle     = 0;
    err_sync     = 0;
    err_pix      = 0;
    err_blank    = 0;
    err_anim     = 0;
    err_uflow    = 0;
    anim_checked = 0;
    tests_run    = 0;
    tests_failed = 0;
    total_errors = 0;
    aligned      = 1'b0;
    @(negedge clk);
    while (reset) begin
      @(negedge clk);
    end
    while (frame_idx < NUM_FRAMES) begin
      s.pix.red = vga_red;
      s.pix.grn = vga_grn;
      s.pix.blu = vga_blu;
      s.hs      = vga_hsync;
      s.vs      = vga_vsync;
      if (underflow) begin
        if (err_uflow == 0) begin
          $display("CHECK FAILED @%0t: underflow flag is set", $time);
        end
        err_uflow++;
      end
      if (aligned) begin
        check_sample(s);
      end else if (!s.hs) begin
        replay_first_line(s);
        aligned = 1'b1;
      end else begin
        pending.push_back(s);
      end
      @(negedge clk);
    end
    finish_run();
  end

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Checks failed");
    $finish;
  end

endmodule

/* vga_timing.sv */
`timescale 1ns/1ns

module vga_timing #(
  parameter int H_VISIBLE = 640,
  parameter int H_FRONT   = 16,
  parameter int H_SYNC    = 96,
  parameter int H_BACK    = 48,
  parameter int V_VISIBLE = 480,
  parameter int V_FRONT   = 10,
  parameter int V_SYNC    = 2,
  parameter int V_BACK    = 33
) (
  input  logic                              clk,
  input  logic                              reset,
  input  gfx_pkg::pixel_t                   pix,
  input  logic                              pix_avail,
  output logic                              take,
  output logic [gfx_pkg::color_bits-1:0]    vga_red,
  output logic [gfx_pkg::color_bits-1:0]    vga_grn,
  output logic [gfx_pkg::color_bits-1:0]    vga_blu,
  output logic                              vga_hsync,
  output logic                              vga_vsync,
  output logic                              underflow
);
  localparam int H_TOTAL = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;
  localparam int HW = $clog2(H_TOTAL + 1);
  localparam int VW = $clog2(V_TOTAL + 1);

  localparam logic [HW-1:0] H_LAST   = HW'(H_TOTAL - 1);
  localparam logic [VW-1:0] V_LAST   = VW'(V_TOTAL - 1);
  localparam logic [HW-1:0] H_VIS    = HW'(H_VISIBLE);
  localparam logic [VW-1:0] V_VIS    = VW'(V_VISIBLE);
  localparam logic [HW-1:0] HS_START = HW'(H_VISIBLE + H_FRONT);
  localparam logic [HW-1:0] HS_END   = HW'(H_VISIBLE + H_FRONT + H_SYNC);
  localparam logic [VW-1:0] VS_START = VW'(V_VISIBLE + V_FRONT);
  localparam logic [VW-1:0] VS_END   = VW'(V_VISIBLE + V_FRONT + V_SYNC);

  logic [HW-1:0] h_cnt;
  logic [VW-1:0] v_cnt;
  logic          started;
  logic          visible;
  logic          hs_win;
  logic          vs_win;

  assign visible = (h_cnt < H_VIS) && (v_cnt < V_VIS);
  assign hs_win  = (h_cnt >= HS_START) && (h_cnt < HS_END);
  assign vs_win  = (v_cnt >= VS_START) && (v_cnt < VS_END);
  assign take    = started && visible;

  // Scan holds at the origin until the pixel queue is primed.
  always_ff @(posedge clk) begin
    if (reset) begin
      h_cnt   <= '0;
      v_cnt   <= '0;
      started <= 1'b0;
    end else begin
      started <= started | pix_avail;
      if (started) begin
        if (h_cnt == H_LAST) begin
          h_cnt <= '0;
          v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;
        end else begin
          h_cnt <= h_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      vga_red   <= '0;
      vga_grn   <= '0;
      vga_blu   <= '0;
      vga_hsync <= 1'b1;
      vga_vsync <= 1'b1;
      underflow <= 1'b0;
    end else begin
      vga_red   <= (take && pix_avail) ? pix.red : '0;
      vga_grn   <= (take && pix_avail) ? pix.grn : '0;
      vga_blu   <= (take && pix_avail) ? pix.blu : '0;
      vga_hsync <= ~hs_win;
      vga_vsync <= ~vs_win;
      underflow <= underflow | (take & ~pix_avail);
    end
  end

endmodule
